// ==== verilog/net_cfg.svh ====
`ifndef NET_CFG_SVH
`define NET_CFG_SVH

// lanes per batch and its log2
`define NET_LANES 16
`define NET_LANES_LOG2 4

// payload field widths
`define VALUE_WIDTH 32
`define ID_WIDTH 32

// per-lane result buffer
`define FIFO_DEPTH 16
`define FIFO_ADDR_WIDTH 4

`endif

// ==== verilog/item_pkg.sv ====
`include "net_cfg.svh"

package item_pkg;

    // one accumulated value and the vertex it belongs to
    typedef logic [`VALUE_WIDTH-1:0] value_t;
    typedef logic [`ID_WIDTH-1:0] vertex_id_t;

    // one bit per lane
    typedef logic [`NET_LANES-1:0] lane_mask_t;

    // a whole batch, lane 0 in the low word
    typedef value_t [`NET_LANES-1:0] value_lanes_t;
    typedef vertex_id_t [`NET_LANES-1:0] id_lanes_t;

endpackage

// ==== verilog/network_pkg.sv ====
`include "net_cfg.svh"

package network_pkg;

    import item_pkg::*;

    typedef enum logic {
        SORT_ASC  = 1'b0,
        SORT_DESC = 1'b1
    } sort_dir_t;

    // phase p of the network has p + 1 compare stages
    function automatic int sort_stage_count();
        return `NET_LANES_LOG2 * (`NET_LANES_LOG2 + 1) / 2;
    endfunction

    function automatic int stage_phase(int k);
        int phase;
        phase = 0;
        while (k >= (phase + 1) * (phase + 2) / 2) begin
            phase++;
        end
        return phase;
    endfunction

    // halves every stage inside a phase
    function automatic int stage_step(int k);
        int phase;
        int sub;
        phase = stage_phase(k);
        sub = k - phase * (phase + 1) / 2;
        return 1 << (phase - sub);
    endfunction

    // blocks alternate direction, the last merge is all ascending
    function automatic lane_mask_t stage_dir_mask(int k);
        int phase;
        lane_mask_t mask;
        phase = stage_phase(k);
        mask = '0;
        for (int l = 0; l < `NET_LANES; l++) begin
            if (phase < `NET_LANES_LOG2 - 1 && ((l >> (phase + 1)) & 1) == 0) begin
                mask[l] = 1'b1;
            end
        end
        return mask;
    endfunction

endpackage

// ==== verilog/sort_stage.sv ====
`timescale 1ns/10ps
`include "net_cfg.svh"

module sort_stage import item_pkg::*, network_pkg::*; #(
    parameter int STAGE = 0
) (
    input  logic         clk,
    input  logic         rst,
    input  value_lanes_t in_value,
    input  id_lanes_t    in_id,
    input  lane_mask_t   in_valid,
    output value_lanes_t out_value,
    output id_lanes_t    out_id,
    output lane_mask_t   out_valid
);

    localparam int STEP = stage_step(STAGE);
    localparam lane_mask_t DIR_MASK = stage_dir_mask(STAGE);

    value_lanes_t next_value;
    id_lanes_t    next_id;
    lane_mask_t   next_valid;

    for (genvar l = 0; l < `NET_LANES; l++) begin : g_pair
        if ((l & STEP) == 0) begin : g_lo
            localparam sort_dir_t DIR = DIR_MASK[l] ? SORT_DESC : SORT_ASC;
            localparam int HI = l + STEP;

            logic lo_v;
            logic hi_v;
            logic keep;

            assign lo_v = in_valid[l];
            assign hi_v = in_valid[HI];

            // invalid entries count as the smallest key
            assign keep = (lo_v && hi_v &&
                           ((DIR == SORT_ASC && in_id[HI] >= in_id[l]) ||
                            (DIR == SORT_DESC && in_id[HI] <= in_id[l]))) ||
                          (lo_v && !hi_v && DIR == SORT_DESC) ||
                          (!lo_v && hi_v && DIR == SORT_ASC);

            assign next_value[l]  = keep ? in_value[l] : in_value[HI];
            assign next_id[l]     = keep ? in_id[l] : in_id[HI];
            assign next_valid[l]  = keep ? lo_v : hi_v;
            assign next_value[HI] = keep ? in_value[HI] : in_value[l];
            assign next_id[HI]    = keep ? in_id[HI] : in_id[l];
            assign next_valid[HI] = keep ? hi_v : lo_v;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else begin
            out_valid <= next_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_value <= next_value;
        out_id <= next_id;
    end

endmodule

// ==== verilog/batch_sort.sv ====
`timescale 1ns/10ps

module batch_sort import item_pkg::*, network_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  value_lanes_t in_value,
    input  id_lanes_t    in_id,
    input  lane_mask_t   in_valid,
    output value_lanes_t out_value,
    output id_lanes_t    out_id,
    output lane_mask_t   out_valid
);

    localparam int STAGES = sort_stage_count();
    localparam int CNT_W = $clog2(STAGES + 1);
    localparam logic [CNT_W-1:0] SETTLED = CNT_W'(STAGES);

    value_lanes_t stage_value [STAGES+1];
    id_lanes_t    stage_id [STAGES+1];
    lane_mask_t   stage_valid [STAGES+1];
    logic [CNT_W-1:0] settle_cnt;

    assign stage_value[0] = in_value;
    assign stage_id[0] = in_id;
    assign stage_valid[0] = in_valid;

    for (genvar k = 0; k < STAGES; k++) begin : g_stage
        sort_stage #(
            .STAGE(k)
        ) sort_stage_i (
            .clk       (clk),
            .rst       (rst),
            .in_value  (stage_value[k]),
            .in_id     (stage_id[k]),
            .in_valid  (stage_valid[k]),
            .out_value (stage_value[k+1]),
            .out_id    (stage_id[k+1]),
            .out_valid (stage_valid[k+1])
        );
    end

    assign out_value = stage_value[STAGES];
    assign out_id = stage_id[STAGES];
    assign out_valid = stage_valid[STAGES];

    // cycles since reset, saturates once the network is refilled
    always_ff @(posedge clk) begin
        if (rst) begin
            settle_cnt <= '0;
        end else if (settle_cnt != SETTLED) begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // the network only permutes entries, never drops or creates one
    a_count_kept: assert property (@(posedge clk) disable iff (rst)
        settle_cnt == SETTLED |-> $countones(out_valid) == $countones($past(in_valid, STAGES)));

endmodule

// ==== verilog/segment_min_scan.sv ====
`timescale 1ns/10ps
`include "net_cfg.svh"

module segment_min_scan import item_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  value_lanes_t in_value,
    input  id_lanes_t    in_id,
    input  lane_mask_t   in_valid,
    output value_lanes_t out_value,
    output id_lanes_t    out_id,
    output lane_mask_t   out_valid
);

    localparam int LEVELS = `NET_LANES_LOG2;

    value_lanes_t lvl_value [LEVELS+1];
    id_lanes_t    lvl_id [LEVELS+1];
    lane_mask_t   lvl_valid [LEVELS+1];

    // sorted batch has all invalid lanes packed at the bottom
    lane_mask_t low_gap;
    logic       in_sorted;

    assign low_gap = ~in_valid;
    assign in_sorted = (low_gap & (low_gap + 1'b1)) == '0;

    assign lvl_value[0] = in_value;
    assign lvl_id[0] = in_id;
    assign lvl_valid[0] = in_valid;

    for (genvar k = 0; k < LEVELS; k++) begin : g_level
        localparam int HALF = 1 << k;

        value_lanes_t next_value;
        id_lanes_t    next_id;
        lane_mask_t   next_valid;

        for (genvar l = 0; l < `NET_LANES; l++) begin : g_lane
            // last lane of the lower half of this block
            localparam int PARTNER = (l / (2 * HALF)) * (2 * HALF) + HALF - 1;
            localparam bit UPPER = (l % (2 * HALF)) >= HALF;

            logic own_v;
            logic par_v;
            logic take;

            assign own_v = lvl_valid[k][l];
            assign par_v = lvl_valid[k][PARTNER];
            assign take = UPPER &&
                          ((par_v && own_v && lvl_id[k][PARTNER] == lvl_id[k][l] &&
                            lvl_value[k][PARTNER] < lvl_value[k][l]) ||
                           (par_v && !own_v));

            assign next_value[l] = take ? lvl_value[k][PARTNER] : lvl_value[k][l];
            assign next_id[l] = take ? lvl_id[k][PARTNER] : lvl_id[k][l];
            assign next_valid[l] = take ? par_v : own_v;
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                lvl_valid[k+1] <= '0;
            end else begin
                lvl_valid[k+1] <= next_valid;
            end
        end

        always_ff @(posedge clk) begin
            lvl_value[k+1] <= next_value;
            lvl_id[k+1] <= next_id;
        end

        // with sorted input an empty lane never borrows a partner entry
        a_no_new_valid: assert property (@(posedge clk) disable iff (rst)
            $past(in_sorted, k + 1) |-> (lvl_valid[k+1] & ~$past(lvl_valid[k])) == '0);
    end

    assign out_value = lvl_value[LEVELS];
    assign out_id = lvl_id[LEVELS];
    assign out_valid = lvl_valid[LEVELS];

endmodule

// ==== verilog/lane_fifo.sv ====
`timescale 1ns/10ps
`include "net_cfg.svh"

module lane_fifo import item_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       write,
    input  value_t     write_value,
    input  vertex_id_t write_id,
    input  logic       read,
    output value_t     read_value,
    output vertex_id_t read_id,
    output logic       empty
);

    localparam logic [`FIFO_ADDR_WIDTH:0] FULL_COUNT = `FIFO_DEPTH;

    value_t     mem_value [`FIFO_DEPTH];
    vertex_id_t mem_id [`FIFO_DEPTH];

    logic [`FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [`FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [`FIFO_ADDR_WIDTH:0]   count;
    logic                        full;

    assign empty = count == '0;
    assign full = count == FULL_COUNT;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({write, read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem_value[wr_ptr] <= write_value;
            mem_id[wr_ptr] <= write_id;
        end
    end

    // read data lands one cycle after the pop
    always_ff @(posedge clk) begin
        if (read) begin
            read_value <= mem_value[rd_ptr];
            read_id <= mem_id[rd_ptr];
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) write |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) read |-> !empty);

endmodule

// ==== verilog/result_drain.sv ====
`timescale 1ns/10ps
`include "net_cfg.svh"

module result_drain import item_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  value_lanes_t lane_value,
    input  id_lanes_t    lane_id,
    input  lane_mask_t   lane_valid,
    output value_t       out_value,
    output vertex_id_t   out_id,
    output logic         out_valid
);

    logic [`NET_LANES_LOG2-1:0] sel;
    logic [`NET_LANES_LOG2-1:0] last_sel;

    lane_mask_t   fifo_empty;
    lane_mask_t   fifo_read;
    value_lanes_t fifo_value;
    id_lanes_t    fifo_id;

    for (genvar l = 0; l < `NET_LANES; l++) begin : g_lane
        // pop only the selected lane, and only if it holds something
        assign fifo_read[l] = (int'(sel) == l) && !fifo_empty[l];

        lane_fifo lane_fifo_i (
            .clk         (clk),
            .rst         (rst),
            .write       (lane_valid[l]),
            .write_value (lane_value[l]),
            .write_id    (lane_id[l]),
            .read        (fifo_read[l]),
            .read_value  (fifo_value[l]),
            .read_id     (fifo_id[l]),
            .empty       (fifo_empty[l])
        );
    end

    // selector walks every lane, empty ones just cost a cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= '0;
            last_sel <= '0;
            out_valid <= 1'b0;
        end else begin
            sel <= sel + 1'b1;
            last_sel <= sel;
            out_valid <= |fifo_read;
        end
    end

    // fifo read data is already registered
    assign out_value = fifo_value[last_sel];
    assign out_id = fifo_id[last_sel];

endmodule

// ==== verilog/sort_accumulate_top.sv ====
`timescale 1ns/10ps

module sort_accumulate_top import item_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  value_lanes_t in_value,
    input  id_lanes_t    in_id,
    input  lane_mask_t   in_valid,
    output value_t       out_value,
    output vertex_id_t   out_id,
    output logic         out_valid
);

    value_lanes_t sorted_value;
    id_lanes_t    sorted_id;
    lane_mask_t   sorted_valid;

    value_lanes_t scan_value;
    id_lanes_t    scan_id;
    lane_mask_t   scan_valid;

    batch_sort batch_sort_i (
        .clk       (clk),
        .rst       (rst),
        .in_value  (in_value),
        .in_id     (in_id),
        .in_valid  (in_valid),
        .out_value (sorted_value),
        .out_id    (sorted_id),
        .out_valid (sorted_valid)
    );

    segment_min_scan segment_min_scan_i (
        .clk       (clk),
        .rst       (rst),
        .in_value  (sorted_value),
        .in_id     (sorted_id),
        .in_valid  (sorted_valid),
        .out_value (scan_value),
        .out_id    (scan_id),
        .out_valid (scan_valid)
    );

    result_drain result_drain_i (
        .clk        (clk),
        .rst        (rst),
        .lane_value (scan_value),
        .lane_id    (scan_id),
        .lane_valid (scan_valid),
        .out_value  (out_value),
        .out_id     (out_id),
        .out_valid  (out_valid)
    );

endmodule

// ==== test/tb_sort_accumulate.sv ====
`timescale 1ns/10ps
`include "net_cfg.svh"

module tb_sort_accumulate import item_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int LANES = `NET_LANES;
    localparam int PIPE_CYCLES = 14;
    localparam int BATCH_CYCLES = PIPE_CYCLES + LANES + 8;
    localparam int TOTAL_BATCHES = 7;
    localparam int WATCHDOG_CYCLES = TOTAL_BATCHES * BATCH_CYCLES + 50;

    logic         clk;
    logic         rst;
    value_lanes_t in_value;
    id_lanes_t    in_id;
    lane_mask_t   in_valid;
    value_t       out_value;
    vertex_id_t   out_id;
    logic         out_valid;

    integer seed;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;

    // valid entries sent in the current test
    vertex_id_t exp_id_q[$];
    value_t     exp_val_q[$];
    int         exp_count[vertex_id_t];
    value_t     exp_min[vertex_id_t];
    // entries parked in masked-off lanes
    vertex_id_t bad_id_q[$];
    value_t     bad_val_q[$];
    vertex_id_t got_id_q[$];
    value_t     got_val_q[$];

    sort_accumulate_top sort_accumulate_top_i (
        .clk       (clk),
        .rst       (rst),
        .in_value  (in_value),
        .in_id     (in_id),
        .in_valid  (in_valid),
        .out_value (out_value),
        .out_id    (out_id),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            got_id_q.push_back(out_id);
            got_val_q.push_back(out_value);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d clock periods, the run timed out", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    task automatic report_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        test_errors++;
    endtask

    task automatic clear_expect();
        exp_id_q.delete();
        exp_val_q.delete();
        exp_count.delete();
        exp_min.delete();
        bad_id_q.delete();
        bad_val_q.delete();
        got_id_q.delete();
        got_val_q.delete();
        test_errors = 0;
    endtask

    // one batch on the next falling edge
    task automatic send_batch(input logic distinct, input vertex_id_t id_base,
                              input lane_mask_t mask);
        int unsigned r;
        vertex_id_t  id;
        value_t      val;
        @(negedge clk);
        for (int l = 0; l < LANES; l++) begin
            r = $random(seed);
            if (distinct) begin
                id = {4'h0, r[23:0], 4'(l)};
            end else begin
                id = id_base + r % 3;
            end
            r = $random(seed);
            val = {1'b0, r[30:0]};
            if (mask[l]) begin
                exp_id_q.push_back(id);
                exp_val_q.push_back(val);
                if (!exp_count.exists(id)) begin
                    exp_count[id] = 0;
                    exp_min[id] = val;
                end
                exp_count[id]++;
                if (val < exp_min[id]) begin
                    exp_min[id] = val;
                end
            end else begin
                // top bits keep masked entries apart from live ones
                id = {4'hf, id[27:0]};
                val = {1'b1, val[30:0]};
                bad_id_q.push_back(id);
                bad_val_q.push_back(val);
            end
            in_id[l] = id;
            in_value[l] = val;
        end
        in_valid = mask;
    endtask

    task automatic stop_input();
        @(negedge clk);
        in_valid = '0;
    endtask

    task automatic wait_results(input int batches);
        int waited;
        waited = 0;
        while (got_id_q.size() < exp_id_q.size() && waited < batches * BATCH_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        assert (got_id_q.size() >= exp_id_q.size()) else begin
            $display("only %0d of %0d results arrived before the wait limit",
                     got_id_q.size(), exp_id_q.size());
            test_errors++;
        end
        // a stray entry would still leave within one selector round
        repeat (LANES + 1) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", name, test_errors);
        end
    endtask

    task automatic check_results(input string name);
        int         got_count[vertex_id_t];
        value_t     got_min[vertex_id_t];
        bit         found;
        bit         masked;
        int         n;
        vertex_id_t id;
        value_t     val;
        assert (got_id_q.size() == exp_id_q.size())
        else report_mismatch($sformatf("%s: %0d pairs out, %0d expected",
                                       name, got_id_q.size(), exp_id_q.size()));
        foreach (got_id_q[i]) begin
            id = got_id_q[i];
            val = got_val_q[i];
            found = 1'b0;
            masked = 1'b0;
            foreach (exp_id_q[j]) begin
                if (exp_id_q[j] == id && exp_val_q[j] == val) begin
                    found = 1'b1;
                end
            end
            foreach (bad_id_q[j]) begin
                if (bad_id_q[j] == id || bad_val_q[j] == val) begin
                    masked = 1'b1;
                end
            end
            assert (found)
            else report_mismatch($sformatf("%s: id %h value %h was never sent", name, id, val));
            assert (!masked)
            else report_mismatch($sformatf("%s: id %h value %h from a masked lane",
                                           name, id, val));
            if (!got_count.exists(id)) begin
                got_count[id] = 0;
                got_min[id] = val;
            end
            got_count[id]++;
            if (val < got_min[id]) begin
                got_min[id] = val;
            end
        end
        foreach (exp_count[k]) begin
            n = got_count.exists(k) ? got_count[k] : 0;
            assert (n == exp_count[k])
            else report_mismatch($sformatf("%s: id %h out %0d times, sent %0d times",
                                           name, k, n, exp_count[k]));
            assert (n == 0 || got_min[k] == exp_min[k])
            else report_mismatch($sformatf("%s: id %h smallest out %h, expected %h",
                                           name, k, got_min[k], exp_min[k]));
        end
        finish_test(name);
    endtask

    initial begin
        lane_mask_t mask;
        seed = 32'h7b67_6916;
        rst = 1'b1;
        in_value = '0;
        in_id = '0;
        in_valid = '0;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        clear_expect();
        repeat (40) begin
            @(negedge clk);
            assert (!out_valid) else report_mismatch("out_valid set with no input after reset");
        end
        finish_test("reset");

        clear_expect();
        send_batch(1'b1, '0, '1);
        stop_input();
        wait_results(1);
        check_results("distinct_ids");

        clear_expect();
        send_batch(1'b0, 32'h100, '1);
        stop_input();
        wait_results(1);
        check_results("repeated_ids");

        clear_expect();
        mask = lane_mask_t'($random(seed));
        send_batch(1'b0, 32'h180, mask);
        stop_input();
        wait_results(1);
        check_results("partial_mask");

        // back to back, one id range per batch
        clear_expect();
        for (int b = 0; b < 4; b++) begin
            mask = lane_mask_t'($random(seed));
            send_batch(1'b0, 32'h200 + 32'(b) * 32'h10, mask);
        end
        stop_input();
        wait_results(4);
        check_results("batches_in_flight");

        $display("tests run: %0d, failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/item_pkg.sv
verilog/network_pkg.sv
verilog/sort_stage.sv
verilog/batch_sort.sv
verilog/segment_min_scan.sv
verilog/lane_fifo.sv
verilog/result_drain.sv
verilog/sort_accumulate_top.sv
test/tb_sort_accumulate.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_sort_accumulate \
    -f filelist.f \
    && ./obj_dir/Vtb_sort_accumulate | tee /dev/stderr | grep -F '** PASS **' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
